// File: design/dec_ex_if.sv
`default_nettype none
`timescale 1ns/100ps

interface dec_ex_if import rv_exec_pkg::*; ();

    logic                  valid;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  is_branch;
    logic                  is_jump;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_target;
    logic                  store;
    logic [XLEN-1:0]       store_data;
    res_src_t              res_src;

    modport decode_mp (
        output valid, alu_op, op1, op2, rd, reg_write, is_branch, is_jump,
               funct3, pc, pc_target, store, store_data, res_src
    );

    modport execute_mp (
        input  valid, alu_op, op1, op2, rd, reg_write, is_branch, is_jump,
               funct3, pc, pc_target, store, store_data, res_src
    );

endinterface

`default_nettype wire

// File: design/ex_res_if.sv
`default_nettype none
`timescale 1ns/100ps

interface ex_res_if import rv_exec_pkg::*; ();

    logic                  valid;
    logic [XLEN-1:0]       alu_result;
    logic [1:0]            addr_lo;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    res_src_t              res_src;
    logic [XLEN-1:0]       pc_next;
    logic                  store;
    logic [XLEN-1:0]       store_data;
    logic [2:0]            funct3;
    logic                  branch_taken;
    logic [XLEN-1:0]       pc_target;

    modport execute_mp (
        output valid, alu_result, addr_lo, rd, reg_write, res_src, pc_next,
               store, store_data, funct3, branch_taken, pc_target
    );

    modport result_mp (
        input  valid, alu_result, addr_lo, rd, reg_write, res_src, pc_next,
               store, store_data, funct3, branch_taken, pc_target
    );

endinterface

`default_nettype wire

// File: design/rv_decode.sv
`default_nettype none
`timescale 1ns/100ps

module rv_decode import rv_exec_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_valid,
    input  wire [31:0]           i_instr,
    input  wire [XLEN-1:0]       i_rs1_data,
    input  wire [XLEN-1:0]       i_rs2_data,
    input  wire [XLEN-1:0]       i_pc,
    input  wire                  i_exec_busy,
    output logic                 o_ready,
    dec_ex_if.decode_mp          o_dec
);

    logic [6:0]            opcode;
    logic [6:0]            funct7;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       jalr_sum;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       op2;
    logic                  reg_write;
    logic                  is_branch;
    logic                  is_jump;
    logic                  store;
    res_src_t              res_src;
    logic [XLEN-1:0]       pc_target;

    function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
        3'b000:  op = alt ? ALU_SUB : ALU_ADD;
        3'b001:  op = ALU_SLL;
        3'b010:  op = ALU_SLT;
        3'b011:  op = ALU_SLTU;
        3'b100:  op = ALU_XOR;
        3'b101:  op = alt ? ALU_SRA : ALU_SRL;
        3'b110:  op = ALU_OR;
        default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    assign jalr_sum = i_rs1_data + imm_i;

    always_comb
    begin
        alu_op    = ALU_ADD;
        op2       = imm_i;
        reg_write = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        store     = 1'b0;
        res_src   = RES_ALU;
        pc_target = i_pc + imm_b;
        case (opcode)
        OPC_OP:
        begin
            op2       = i_rs2_data;
            reg_write = 1'b1;
            if (funct7 == 7'b0000001)
            begin
                case (funct3)
                3'b000:  alu_op = ALU_MUL;
                3'b001:  alu_op = ALU_MULH;
                3'b010:  alu_op = ALU_MULHSU;
                3'b011:  alu_op = ALU_MULHU;
                default: reg_write = 1'b0;    // no divider
                endcase
            end
            else
                alu_op = base_op(funct3, funct7[5]);
        end
        OPC_OP_IMM:
        begin
            reg_write = 1'b1;
            alu_op    = base_op(funct3, funct7[5] && (funct3 == 3'b101));  // srai only
        end
        OPC_BRANCH:
        begin
            op2       = i_rs2_data;
            alu_op    = ALU_SUB;
            is_branch = 1'b1;
        end
        OPC_STORE:
        begin
            op2   = imm_s;
            store = 1'b1;
        end
        OPC_JAL:
        begin
            op2       = imm_j;
            reg_write = 1'b1;
            is_jump   = 1'b1;
            res_src   = RES_PC_NEXT;
            pc_target = i_pc + imm_j;
        end
        OPC_JALR:
        begin
            reg_write = 1'b1;
            is_jump   = 1'b1;
            res_src   = RES_PC_NEXT;
            pc_target = {jalr_sum[XLEN-1:1], 1'b0};
        end
        OPC_LUI:
        begin
            op2       = imm_u;
            alu_op    = ALU_PASS_B;
            reg_write = 1'b1;
        end
        default: ;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_dec.valid <= 1'b0;
        else
            o_dec.valid <= i_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_dec.alu_op     <= alu_op;
            o_dec.op1        <= i_rs1_data;
            o_dec.op2        <= op2;
            o_dec.rd         <= rd;
            o_dec.reg_write  <= reg_write;
            o_dec.is_branch  <= is_branch;
            o_dec.is_jump    <= is_jump;
            o_dec.funct3     <= funct3;
            o_dec.pc         <= i_pc;
            o_dec.pc_target  <= pc_target;
            o_dec.store      <= store;
            o_dec.store_data <= i_rs2_data;
            o_dec.res_src    <= res_src;
        end
    end

    // hold off new work while a multiply is queued or running
    assign o_ready = !(i_exec_busy || (o_dec.valid && is_mul_op(o_dec.alu_op)));

endmodule

`default_nettype wire

// File: design/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STRB_W     = XLEN / 8;
    localparam int MUL_STEPS  = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_STEPS);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_MUL    = 4'd10,
        ALU_MULH   = 4'd11,
        ALU_MULHSU = 4'd12,
        ALU_MULHU  = 4'd13,
        ALU_PASS_B = 4'd14    // lui
    } alu_op_t;

    typedef enum logic {
        RES_ALU     = 1'b0,
        RES_PC_NEXT = 1'b1
    } res_src_t;

    function automatic logic is_mul_op(input alu_op_t op);
        return op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    endfunction

endpackage

`default_nettype wire

// File: design/rv_exec_top.sv
`default_nettype none
`timescale 1ns/100ps

module rv_exec_top import rv_exec_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_valid,
    input  wire [31:0]             i_instr,
    input  wire [XLEN-1:0]         i_rs1_data,
    input  wire [XLEN-1:0]         i_rs2_data,
    input  wire [XLEN-1:0]         i_pc,
    output logic                   o_ready,
    output logic                   o_valid,
    output logic [XLEN-1:0]        o_result,
    output logic [REG_ADDR_W-1:0]  o_rd,
    output logic                   o_reg_write,
    output logic                   o_branch_taken,
    output logic [XLEN-1:0]        o_pc_target,
    output logic                   o_store,
    output logic [XLEN-1:0]        o_addr,
    output logic [XLEN-1:0]        o_wdata,
    output logic [STRB_W-1:0]      o_wsel
);

    logic exec_busy;

    dec_ex_if u_dec_ex_if ();
    ex_res_if u_ex_res_if ();

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_instr        (i_instr),
        .i_rs1_data     (i_rs1_data),
        .i_rs2_data     (i_rs2_data),
        .i_pc           (i_pc),
        .i_exec_busy    (exec_busy),
        .o_ready        (o_ready),
        .o_dec          (u_dec_ex_if.decode_mp)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_dec          (u_dec_ex_if.execute_mp),
        .o_ex           (u_ex_res_if.execute_mp),
        .o_busy         (exec_busy)
    );

    rv_result u_result
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_ex           (u_ex_res_if.result_mp),
        .o_valid        (o_valid),
        .o_result       (o_result),
        .o_rd           (o_rd),
        .o_reg_write    (o_reg_write),
        .o_branch_taken (o_branch_taken),
        .o_pc_target    (o_pc_target),
        .o_store        (o_store),
        .o_addr         (o_addr),
        .o_wdata        (o_wdata),
        .o_wsel         (o_wsel)
    );

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none
`timescale 1ns/100ps

module rv_execute import rv_exec_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_reset,
    dec_ex_if.execute_mp         i_dec,
    ex_res_if.execute_mp         o_ex,
    output logic                 o_busy
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} mul_state_t;

    mul_state_t           state;
    logic                 start_mul;
    logic                 sub_op;
    logic [XLEN-1:0]      add_b;
    logic [XLEN:0]        sum;
    logic                 eq;
    logic                 lts;
    logic                 ltu;
    logic                 cmp;
    logic                 taken;
    logic [XLEN-1:0]      alu_out;
    logic [XLEN-1:0]      alu_q;
    logic                 sc_valid;
    logic [XLEN:0]        mcand;
    logic [XLEN:0]        acc_hi;
    logic [XLEN-1:0]      acc_lo;
    logic [XLEN+1:0]      addend;
    logic [XLEN+1:0]      step_sum;
    logic [MUL_CNT_W-1:0] step_cnt;
    logic                 last_step;
    logic                 mul_hi;
    logic                 op2_signed;

    assign start_mul = i_dec.valid && is_mul_op(i_dec.alu_op);

    // everything but add subtracts on the shared adder
    assign sub_op = (i_dec.alu_op != ALU_ADD);
    assign add_b  = sub_op ? ~i_dec.op2 : i_dec.op2;
    assign sum    = {1'b0, i_dec.op1} + {1'b0, add_b} + {{XLEN{1'b0}}, sub_op};

    assign eq  = (i_dec.op1 == i_dec.op2);
    assign ltu = !sum[XLEN];    // no carry out on subtract
    assign lts = (i_dec.op1[XLEN-1] != i_dec.op2[XLEN-1]) ? i_dec.op1[XLEN-1] : sum[XLEN-1];

    always_comb
    begin
        case (i_dec.funct3[2:1])
        2'b00:   cmp = eq;
        2'b10:   cmp = lts;
        2'b11:   cmp = ltu;
        default: cmp = 1'b0;
        endcase
    end

    assign taken = i_dec.is_jump || (i_dec.is_branch && (cmp ^ i_dec.funct3[0]));

    always_comb
    begin
        case (i_dec.alu_op)
        ALU_ADD,
        ALU_SUB:    alu_out = sum[XLEN-1:0];
        ALU_SLL:    alu_out = i_dec.op1 << i_dec.op2[4:0];
        ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lts};
        ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, ltu};
        ALU_XOR:    alu_out = i_dec.op1 ^ i_dec.op2;
        ALU_SRL:    alu_out = i_dec.op1 >> i_dec.op2[4:0];
        ALU_SRA:    alu_out = $signed(i_dec.op1) >>> i_dec.op2[4:0];
        ALU_OR:     alu_out = i_dec.op1 | i_dec.op2;
        ALU_AND:    alu_out = i_dec.op1 & i_dec.op2;
        ALU_PASS_B: alu_out = i_dec.op2;
        default:    alu_out = '0;    // multiplies come from the iterative path
        endcase
    end

    // op2 shifts out of the bottom of acc_lo
    assign last_step = (step_cnt == MUL_CNT_W'(MUL_STEPS - 1));
    assign addend    = !acc_lo[0] ? '0 :
                       (last_step && op2_signed) ? -{mcand[XLEN], mcand} :
                       {mcand[XLEN], mcand};
    assign step_sum  = {acc_hi[XLEN], acc_hi} + addend;

    always_ff @(posedge i_clk)
    begin
        if (start_mul)
        begin
            mcand      <= {i_dec.op1[XLEN-1] && (i_dec.alu_op != ALU_MULHU), i_dec.op1};
            acc_hi     <= '0;
            acc_lo     <= i_dec.op2;
            step_cnt   <= '0;
            mul_hi     <= (i_dec.alu_op != ALU_MUL);
            op2_signed <= (i_dec.alu_op inside {ALU_MUL, ALU_MULH});
        end
        else if (state == ST_RUN)
        begin
            acc_hi   <= step_sum[XLEN+1:1];
            acc_lo   <= {step_sum[0], acc_lo[XLEN-1:1]};
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state    <= ST_IDLE;
            sc_valid <= 1'b0;
        end
        else
        begin
            sc_valid <= i_dec.valid && !is_mul_op(i_dec.alu_op);
            case (state)
            ST_IDLE: state <= start_mul ? ST_RUN : ST_IDLE;
            ST_RUN:  state <= last_step ? ST_DONE : ST_RUN;
            default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_dec.valid)
        begin
            alu_q             <= alu_out;
            o_ex.addr_lo      <= sum[1:0];
            o_ex.rd           <= i_dec.rd;
            o_ex.reg_write    <= i_dec.reg_write;
            o_ex.res_src      <= i_dec.res_src;
            o_ex.pc_next      <= i_dec.pc + XLEN'(4);
            o_ex.store        <= i_dec.store;
            o_ex.store_data   <= i_dec.store_data;
            o_ex.funct3       <= i_dec.funct3;
            o_ex.branch_taken <= taken;
            o_ex.pc_target    <= i_dec.pc_target;
        end
    end

    assign o_busy          = (state == ST_RUN);
    assign o_ex.valid      = sc_valid || (state == ST_DONE);
    assign o_ex.alu_result = (state != ST_DONE) ? alu_q :
                             mul_hi ? acc_hi[XLEN-1:0] : acc_lo;

endmodule

`default_nettype wire

// File: design/rv_result.sv
`default_nettype none
`timescale 1ns/100ps

module rv_result import rv_exec_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_reset,
    ex_res_if.result_mp            i_ex,
    output logic                   o_valid,
    output logic [XLEN-1:0]        o_result,
    output logic [REG_ADDR_W-1:0]  o_rd,
    output logic                   o_reg_write,
    output logic                   o_branch_taken,
    output logic [XLEN-1:0]        o_pc_target,
    output logic                   o_store,
    output logic [XLEN-1:0]        o_addr,
    output logic [XLEN-1:0]        o_wdata,
    output logic [STRB_W-1:0]      o_wsel
);

    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wsel;

    assign result = (i_ex.res_src == RES_PC_NEXT) ? i_ex.pc_next : i_ex.alu_result;

    always_comb
    begin
        case (i_ex.funct3[1:0])
        2'b00:
        begin
            wdata = {4{i_ex.store_data[7:0]}};
            wsel  = 4'b0001 << i_ex.addr_lo;
        end
        2'b01:
        begin
            wdata = {2{i_ex.store_data[15:0]}};
            wsel  = 4'b0011 << {i_ex.addr_lo[1], 1'b0};    // halfword aligned
        end
        default:
        begin
            wdata = i_ex.store_data;
            wsel  = '1;
        end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_valid        <= 1'b0;
            o_reg_write    <= 1'b0;
            o_store        <= 1'b0;
            o_branch_taken <= 1'b0;
        end
        else
        begin
            o_valid        <= i_ex.valid;
            o_reg_write    <= i_ex.valid && i_ex.reg_write;
            o_store        <= i_ex.valid && i_ex.store;
            o_branch_taken <= i_ex.valid && i_ex.branch_taken;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ex.valid)
        begin
            o_result    <= result;
            o_rd        <= i_ex.rd;
            o_pc_target <= i_ex.pc_target;
            o_addr      <= i_ex.alu_result;    // store address
            o_wdata     <= wdata;
            o_wsel      <= i_ex.store ? wsel : '0;
        end
    end

endmodule

`default_nettype wire

// File: dv/rv_exec_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module rv_exec_assertions import rv_exec_pkg::*;
(
    input wire                    i_clk,
    input wire                    i_reset,
    input wire                    i_valid,
    input wire [31:0]             i_instr,
    input wire [XLEN-1:0]         i_rs1_data,
    input wire [XLEN-1:0]         i_rs2_data,
    input wire [XLEN-1:0]         i_pc,
    input wire                    o_ready,
    input wire                    o_valid,
    input wire [XLEN-1:0]         o_result,
    input wire [REG_ADDR_W-1:0]   o_rd,
    input wire                    o_reg_write,
    input wire                    o_branch_taken,
    input wire [XLEN-1:0]         o_pc_target,
    input wire                    o_store,
    input wire [XLEN-1:0]         o_addr,
    input wire [XLEN-1:0]         o_wdata,
    input wire [STRB_W-1:0]       o_wsel
);

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        wr;
        logic        taken;
        logic        chk_tgt;
        logic [31:0] target;
        logic        store;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wsel;
        logic        is_mul;
        logic [31:0] due;
    } exp_t;

    exp_t        q [8];
    exp_t        hd;
    logic [2:0]  wp;
    logic [2:0]  rp;
    int          cnt;
    logic [31:0] cyc;
    int          fail_cnt = 0;
    logic        push;
    logic        is_mul_in;

    // reference rules straight from the RV32IM spec
    function automatic exp_t model(input logic [31:0] ins, input logic [31:0] a,
                                   input logic [31:0] b, input logic [31:0] pc);
        exp_t        e;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] y;
        logic [63:0] pa;
        logic [63:0] pb;
        logic [63:0] prod;
        e     = '0;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e.rd  = ins[11:7];
        case (ins[6:0])
        OPC_OP, OPC_OP_IMM:
        begin
            e.wr = 1'b1;
            y    = (ins[6:0] == OPC_OP) ? b : imm_i;
            if (ins[6:0] == OPC_OP && ins[31:25] == 7'h01)
            begin
                pa       = (f3 == 3'b011) ? {32'b0, a} : {{32{a[31]}}, a};
                pb       = f3[1] ? {32'b0, b} : {{32{b[31]}}, b};
                prod     = pa * pb;
                e.result = (f3 == 3'b000) ? prod[31:0] : prod[63:32];
                e.is_mul = 1'b1;
            end
            else
            begin
                case (f3)
                3'd0: e.result = (ins[6:0] == OPC_OP && ins[30]) ? a - y : a + y;
                3'd1: e.result = a << y[4:0];
                3'd2: e.result = {31'b0, $signed(a) < $signed(y)};
                3'd3: e.result = {31'b0, a < y};
                3'd4: e.result = a ^ y;
                3'd5:
                begin
                    if (ins[30])
                        e.result = $signed(a) >>> y[4:0];
                    else
                        e.result = a >> y[4:0];
                end
                3'd6: e.result = a | y;
                default: e.result = a & y;
                endcase
            end
        end
        OPC_LUI:
        begin
            e.wr     = 1'b1;
            e.result = {ins[31:12], 12'b0};
        end
        OPC_BRANCH:
        begin
            e.chk_tgt = 1'b1;
            e.target  = pc + imm_b;
            case (f3)
            3'd0: e.taken = (a == b);
            3'd1: e.taken = (a != b);
            3'd4: e.taken = $signed(a) < $signed(b);
            3'd5: e.taken = $signed(a) >= $signed(b);
            3'd6: e.taken = a < b;
            default: e.taken = a >= b;
            endcase
        end
        OPC_JAL, OPC_JALR:
        begin
            e.wr      = 1'b1;
            e.taken   = 1'b1;
            e.chk_tgt = 1'b1;
            e.result  = pc + 32'd4;
            e.target  = (ins[6:0] == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
        end
        OPC_STORE:
        begin
            e.store = 1'b1;
            e.addr  = a + imm_s;
            case (f3)
            3'd0:
            begin
                e.wdata = {4{b[7:0]}};
                e.wsel  = 4'b0001 << e.addr[1:0];
            end
            3'd1:
            begin
                e.wdata = {2{b[15:0]}};
                e.wsel  = e.addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                e.wdata = b;
                e.wsel  = 4'b1111;
            end
            endcase
        end
        default: ;
        endcase
        return e;
    endfunction

    assign push      = i_valid && o_ready;
    assign hd        = q[rp];
    assign is_mul_in = (i_instr[6:0] == OPC_OP) && (i_instr[31:25] == 7'h01) && !i_instr[14];

    always_ff @(posedge i_clk)
    begin
        cyc <= i_reset ? '0 : cyc + 1'b1;
        if (i_reset)
        begin
            wp  <= '0;
            rp  <= '0;
            cnt <= 0;
        end
        else
        begin
            if (push)
            begin
                q[wp]     <= model(i_instr, i_rs1_data, i_rs2_data, i_pc);
                q[wp].due <= cyc + (is_mul_in ? 32'(3 + MUL_STEPS) : 32'd3);
                wp        <= wp + 1'b1;
            end
            if (o_valid)
                rp <= rp + 1'b1;
            cnt <= cnt + int'(push) - int'(o_valid && cnt != 0);
        end
    end

    a_strobe_ready: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |-> o_ready)
        else begin $error("strobe arrived while o_ready was low"); fail_cnt = fail_cnt + 1; end

    a_ready_drop: assert property (@(posedge i_clk) disable iff (i_reset)
        (push && is_mul_in) |=> !o_ready)
        else begin $error("o_ready stayed high after a multiply"); fail_cnt = fail_cnt + 1; end

    a_early: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> (cnt != 0 && cyc == hd.due))
        else begin $error("o_valid came at the wrong cycle"); fail_cnt = fail_cnt + 1; end

    a_late: assert property (@(posedge i_clk) disable iff (i_reset)
        (cnt != 0 && cyc == hd.due) |-> o_valid)
        else begin $error("o_valid missing at its due cycle"); fail_cnt = fail_cnt + 1; end

    a_mul_ready: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && hd.is_mul) |-> o_ready)
        else begin $error("o_ready still low at the multiply result"); fail_cnt = fail_cnt + 1; end

    a_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        (cnt == 0) |-> (o_ready && !o_valid && !o_store && !o_reg_write && !o_branch_taken))
        else begin $error("outputs not idle with nothing in flight"); fail_cnt = fail_cnt + 1; end

    a_result: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && hd.wr) |-> (o_result == hd.result && o_rd == hd.rd))
        else begin
            $error("error o_result/o_rd got %h/%h exp %h/%h", $sampled(o_result),
                   $sampled(o_rd), $sampled(hd.result), $sampled(hd.rd));
            fail_cnt = fail_cnt + 1;
        end

    a_ctrl: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> ({o_reg_write, o_store, o_branch_taken} == {hd.wr, hd.store, hd.taken}))
        else begin
            $error("error o_reg_write/o_store/o_branch_taken got %h exp %h",
                   $sampled({o_reg_write, o_store, o_branch_taken}),
                   $sampled({hd.wr, hd.store, hd.taken}));
            fail_cnt = fail_cnt + 1;
        end

    a_target: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && hd.chk_tgt) |-> (o_pc_target == hd.target))
        else begin
            $error("error o_pc_target got %h exp %h", $sampled(o_pc_target),
                   $sampled(hd.target));
            fail_cnt = fail_cnt + 1;
        end

    a_store: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && hd.store) |-> (o_addr == hd.addr && o_wdata == hd.wdata && o_wsel == hd.wsel))
        else begin
            $error("error o_addr/o_wdata/o_wsel got %h/%h/%h exp %h/%h/%h", $sampled(o_addr),
                   $sampled(o_wdata), $sampled(o_wsel), $sampled(hd.addr),
                   $sampled(hd.wdata), $sampled(hd.wsel));
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind rv_exec_top rv_exec_assertions u_chk (.*);

`default_nettype wire

// File: dv/rv_exec_tb.sv
`default_nettype none
`timescale 1ns/100ps

module rv_exec_tb import rv_exec_pkg::*;
();

    localparam int N_OPS = 128;
    localparam int CYCLE_LIMIT = N_OPS * (3 + MUL_STEPS) + 100;

    logic                  i_clk = 1'b0;
    logic                  i_reset;
    logic                  i_valid;
    logic [31:0]           i_instr;
    logic [XLEN-1:0]       i_rs1_data;
    logic [XLEN-1:0]       i_rs2_data;
    logic [XLEN-1:0]       i_pc;
    wire                   o_ready;
    wire                   o_valid;
    wire [XLEN-1:0]        o_result;
    wire [REG_ADDR_W-1:0]  o_rd;
    wire                   o_reg_write;
    wire                   o_branch_taken;
    wire [XLEN-1:0]        o_pc_target;
    wire                   o_store;
    wire [XLEN-1:0]        o_addr;
    wire [XLEN-1:0]        o_wdata;
    wire [STRB_W-1:0]      o_wsel;

    logic [15:0] lfsr = 16'd21059;
    int          cycles = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          fails_before = 0;
    logic [31:0] a;
    logic [31:0] b;

    rv_exec_top u_dut (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [31:0] rs1,
                         input logic [31:0] rs2);
        @(negedge i_clk);
        while (!o_ready)
            @(negedge i_clk);
        @(posedge i_clk);
        i_valid    <= 1'b1;
        i_instr    <= ins;
        i_rs1_data <= rs1;
        i_rs2_data <= rs2;
        i_pc       <= {30'(rand_bits(30)), 2'b00};
        @(posedge i_clk);
        i_valid    <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (u_dut.u_chk.cnt != 0)
            @(posedge i_clk);
        @(posedge i_clk);
        if (u_dut.u_chk.fail_cnt == fails_before)
        begin
            tests_ok++;
            $display("test %s ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s FAILED", name);
        end
        fails_before = u_dut.u_chk.fail_cnt;
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'(rand_bits(5)), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'(rand_bits(5)), opc};
    endfunction

    initial
    begin
        logic [31:0] corner [4];
        logic [11:0] imm;
        logic [12:0] boff;
        corner     = '{32'h0, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF};
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        i_pc       = '0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) @(posedge i_clk);
        finish_test("reset");

        for (int f = 0; f < 8; f++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                issue(enc_r(7'h00, 3'(f)), rand_bits(32), rand_bits(32));
                if (f == 0 || f == 5)
                    issue(enc_r(7'h20, 3'(f)), rand_bits(32), rand_bits(32));
                imm = (f == 1 || f == 5) ? {7'h00, 5'(rand_bits(5))} : 12'(rand_bits(12));
                issue(enc_i(imm, 3'(f), OPC_OP_IMM), rand_bits(32), 32'h0);
                if (f == 5)
                    issue(enc_i({7'h20, 5'(rand_bits(5))}, 3'd5, OPC_OP_IMM),
                          rand_bits(32), 32'h0);
            end
        end
        for (int k = 0; k < 3; k++)
            issue({20'(rand_bits(20)), 5'(rand_bits(5)), OPC_LUI}, 32'h0, 32'h0);
        finish_test("alu");

        for (int f = 0; f < 4; f++)
        begin
            for (int k = 0; k < 3; k++)
                issue(enc_r(7'h01, 3'(f)), rand_bits(32), rand_bits(32));
            for (int k = 1; k < 3; k++)
            begin
                issue(enc_r(7'h01, 3'(f)), corner[k], corner[1]);
                issue(enc_r(7'h01, 3'(f)), corner[k], corner[2]);
            end
        end
        finish_test("multiply");

        foreach (corner[f])
        begin
            a = rand_bits(32);
            issue(enc_r(7'h01, 3'd0), a, rand_bits(32));
            issue(enc_r(7'h00, 3'd0), a, corner[f]);    // queued behind the multiply
        end
        finish_test("ready");

        for (int f = 0; f < 8; f++)
        begin
            if (f == 2 || f == 3)
                continue;
            a    = rand_bits(32);
            b    = a ^ 32'h8000_0000;
            boff = {12'(rand_bits(12)), 1'b0};
            issue({boff[12], boff[10:5], 5'd2, 5'd1, 3'(f), boff[4:1], boff[11], OPC_BRANCH},
                  a, a);
            issue({boff[12], boff[10:5], 5'd2, 5'd1, 3'(f), boff[4:1], boff[11], OPC_BRANCH},
                  a, b);
            issue({boff[12], boff[10:5], 5'd2, 5'd1, 3'(f), boff[4:1], boff[11], OPC_BRANCH},
                  b, a);
        end
        issue({20'(rand_bits(20)), 5'(rand_bits(5)), OPC_JAL}, 32'h0, 32'h0);
        // odd base plus even offset so bit 0 of the target must be cleared
        issue(enc_i({11'(rand_bits(11)), 1'b0}, 3'd0, OPC_JALR),
              rand_bits(31) | 32'h1, 32'h0);
        finish_test("branch");

        for (int f = 0; f < 3; f++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                imm = {10'(rand_bits(10)), 2'(k)};
                issue({imm[11:5], 5'd2, 5'd1, 3'(f), imm[4:0], OPC_STORE},
                      {30'(rand_bits(30)), 2'b00}, rand_bits(32));
            end
        end
        finish_test("store");

        $display("tests passed %0d failed %0d, assertion failures %0d",
                 tests_ok, tests_bad, u_dut.u_chk.fail_cnt);
        if (tests_bad == 0 && u_dut.u_chk.fail_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/rv_exec_pkg.sv
design/dec_ex_if.sv
design/ex_res_if.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_exec_top.sv
dv/rv_exec_assertions.sv
dv/rv_exec_tb.sv
